// File: verilog/vlane_data_pkg.sv
`default_nettype none

package vlane_data_pkg;

  // sizing limits of the lane group, the top level picks values inside them
  localparam int MAX_LANES       = 8;
  localparam int MAX_AMOUNT_BITS = 6;
  localparam int REG_ADDR_BITS   = 5;   // vector register file has 32 entries

  // one bit per lane, lanes above NUM_LANES stay zero
  typedef logic [MAX_LANES-1:0] lane_mask_t;

  // shift amount as carried through the pipe, before the modulo cut
  typedef logic [MAX_AMOUNT_BITS-1:0] amount_t;

  // vector register address
  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;

  // what the unit hands to the writeback port next to result_data
  // an illegal instruction still returns a valid result but writes nothing
  typedef struct packed {
    logic       valid;
    logic       illegal;
    reg_addr_t  dest;
    lane_mask_t write_mask;
  } result_t;

endpackage

`default_nettype wire

// File: verilog/vlane_isa_pkg.sv
`default_nettype none

package vlane_isa_pkg;

  localparam int OPCODE_BITS = 4;

  // opcodes of the shift group, anything else is flagged illegal
  localparam logic [OPCODE_BITS-1:0] OPC_SLL = 4'h1;
  localparam logic [OPCODE_BITS-1:0] OPC_SRL = 4'h2;
  localparam logic [OPCODE_BITS-1:0] OPC_SRA = 4'h3;

  // values of the amount-source bit in the instruction word
  localparam logic AMT_IMM    = 1'b0;
  localparam logic AMT_SCALAR = 1'b1;

  // issued instruction word, 16 bits
  //   [15:12] opcode
  //   [11:7]  destination vector register
  //   [6]     amount source
  //   [5:0]   immediate amount
  typedef struct packed {
    logic [OPCODE_BITS-1:0]  opcode;
    vlane_data_pkg::reg_addr_t dest;
    logic                    amt_src;
    vlane_data_pkg::amount_t imm;
  } instr_t;

  // the shifter reads bit 1 as sign extend and bit 0 as direction
  //
  //   sign_ext dir
  //    0        0   shift left
  //    0        1   shift right logical
  //    1        1   shift right arithmetic
  typedef enum logic [1:0] {
    shift_left        = 2'b00,
    shift_right_logic = 2'b01,
    shift_right_arith = 2'b11
  } shift_op_t;

  // decoded control, registered by the decoder and carried down the pipe
  typedef struct packed {
    logic                       valid;
    logic                       illegal;
    shift_op_t                  op;
    vlane_data_pkg::amount_t    amount;   // already picked from imm or scalar
    vlane_data_pkg::reg_addr_t  dest;
    vlane_data_pkg::lane_mask_t mask;
  } shift_ctrl_t;

endpackage

`default_nettype wire

// File: verilog/vlane_shift_decode.sv
`timescale 1ns/1ps
`default_nettype none

module vlane_shift_decode #(
  parameter int NUM_LANES  = 4,
  parameter int ELEM_WIDTH = 32
) (
  input  wire                                        clk,
  input  wire                                        reset,
  input  wire                                        issue,
  input  vlane_isa_pkg::instr_t                      instr,
  input  wire [vlane_data_pkg::MAX_AMOUNT_BITS-1:0]  scalar_amount,
  input  wire [NUM_LANES-1:0]                        elem_mask,
  input  wire [NUM_LANES*ELEM_WIDTH-1:0]             operand,
  output vlane_isa_pkg::shift_ctrl_t                 ctrl,
  output vlane_isa_pkg::shift_ctrl_t                 ctrl_late,
  output logic [NUM_LANES*ELEM_WIDTH-1:0]            operand_q
);

  import vlane_isa_pkg::*;

  shift_op_t   op_d;
  logic        illegal_d;
  shift_ctrl_t ctrl_d;

  // opcode to shifter operation
  always_comb begin
    illegal_d = 1'b0;
    case (instr.opcode)
      OPC_SLL: op_d = shift_left;
      OPC_SRL: op_d = shift_right_logic;
      OPC_SRA: op_d = shift_right_arith;
      default: begin
        op_d      = shift_left;   // any value works since nothing gets written
        illegal_d = 1'b1;
      end
    endcase
  end

  // assemble the control word for this issue
  always_comb begin
    ctrl_d         = '0;
    ctrl_d.valid   = issue;
    ctrl_d.illegal = illegal_d;
    ctrl_d.op      = op_d;
    ctrl_d.dest    = instr.dest;
    // the full six bits are kept and each lane cuts what its width needs
    if (instr.amt_src == AMT_SCALAR) begin
      ctrl_d.amount = scalar_amount;
    end else begin
      ctrl_d.amount = instr.imm;
    end
    ctrl_d.mask[NUM_LANES-1:0] = elem_mask;   // unused upper lanes stay 0
  end

  // the decode register updates one cycle after issue
  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl <= '0;
    end else begin
      ctrl.valid <= ctrl_d.valid;
      if (issue) begin
        ctrl.illegal <= ctrl_d.illegal;
        ctrl.op      <= ctrl_d.op;
        ctrl.amount  <= ctrl_d.amount;
        ctrl.dest    <= ctrl_d.dest;
        ctrl.mask    <= ctrl_d.mask;
      end
    end
  end

  // operand captured in the same cycle so data and control stay paired
  always_ff @(posedge clk) begin
    if (issue) begin
      operand_q <= operand;
    end
  end

  // a second copy of the control lines up with the shifter partial register
  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_late <= '0;
    end else begin
      ctrl_late <= ctrl;
    end
  end

endmodule

`default_nettype wire

// File: verilog/vlane_barrelshifter.sv
`timescale 1ns/1ps
`default_nettype none

module vlane_barrelshifter #(
  parameter int ELEM_WIDTH  = 32,
  parameter int AMOUNT_BITS = 5,
  parameter int LOW_BITS    = 2     // amount bits applied by the second stage
) (
  input  wire                          clk,
  input  wire                          reset,
  input  vlane_isa_pkg::shift_op_t     op,
  input  wire [AMOUNT_BITS-1:0]        amount,
  input  wire [ELEM_WIDTH-1:0]         opb,
  output logic [ELEM_WIDTH-1:0]        shifted
);

  logic                  sign_ext;
  logic                  dir;        // 1 shifts right
  logic [ELEM_WIDTH:0]   ext;        // element plus one fill bit on top
  logic [AMOUNT_BITS-1:0] amt_hi;
  logic [ELEM_WIDTH:0]   stage1;

  logic [ELEM_WIDTH:0]   partial_q;
  logic                  dir_q;
  logic [LOW_BITS-1:0]   amt_lo_q;
  logic [ELEM_WIDTH:0]   stage2;

  assign sign_ext = op[1];
  assign dir      = op[0];

  // the extra top bit is the fill value for right shifts, so one arithmetic
  // shift covers both logical and arithmetic right shifts
  assign ext = {sign_ext & opb[ELEM_WIDTH-1], opb};

  // first stage takes the upper amount bits only
  assign amt_hi = {amount[AMOUNT_BITS-1:LOW_BITS], {LOW_BITS{1'b0}}};

  always_comb begin
    if (dir) begin
      stage1 = $signed(ext) >>> amt_hi;
    end else begin
      stage1 = ext << amt_hi;   // fill bit is 0 here and falls off the top
    end
  end

  // partial result, no reset on data
  always_ff @(posedge clk) begin
    partial_q <= stage1;
  end

  // direction and low amount bits follow the partial result
  always_ff @(posedge clk) begin
    if (reset) begin
      dir_q    <= 1'b0;
      amt_lo_q <= '0;
    end else begin
      dir_q    <= dir;
      amt_lo_q <= amount[LOW_BITS-1:0];
    end
  end

  // second stage finishes the shift on the registered value
  always_comb begin
    if (dir_q) begin
      stage2 = $signed(partial_q) >>> amt_lo_q;
    end else begin
      stage2 = partial_q << amt_lo_q;
    end
  end

  // top bit is only the fill value, drop it
  assign shifted = stage2[ELEM_WIDTH-1:0];

endmodule

`default_nettype wire

// File: verilog/vlane_shift_result.sv
`timescale 1ns/1ps
`default_nettype none

module vlane_shift_result #(
  parameter int NUM_LANES  = 4,
  parameter int ELEM_WIDTH = 32
) (
  input  wire                               clk,
  input  wire                               reset,
  input  vlane_isa_pkg::shift_ctrl_t        ctrl_late,
  input  wire [NUM_LANES*ELEM_WIDTH-1:0]    shifted_data,
  output vlane_data_pkg::result_t           result,
  output logic [NUM_LANES*ELEM_WIDTH-1:0]   result_data
);

  import vlane_data_pkg::*;

  logic [NUM_LANES-1:0]            wr_mask;
  result_t                         result_d;
  logic [NUM_LANES*ELEM_WIDTH-1:0] data_d;

  // an illegal instruction or an idle slot writes no lane
  assign wr_mask = (ctrl_late.valid && !ctrl_late.illegal) ?
                   ctrl_late.mask[NUM_LANES-1:0] : '0;

  always_comb begin
    result_d                          = '0;
    result_d.valid                    = ctrl_late.valid;
    result_d.illegal                  = ctrl_late.valid & ctrl_late.illegal;
    result_d.dest                     = ctrl_late.dest;
    result_d.write_mask[NUM_LANES-1:0] = wr_mask;
  end

  // lanes that are not written read back as zero
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (wr_mask[i]) begin
        data_d[i*ELEM_WIDTH +: ELEM_WIDTH] = shifted_data[i*ELEM_WIDTH +: ELEM_WIDTH];
      end else begin
        data_d[i*ELEM_WIDTH +: ELEM_WIDTH] = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
    end else begin
      result <= result_d;
    end
  end

  // data follows the struct without a reset
  always_ff @(posedge clk) begin
    result_data <= data_d;
  end

endmodule

`default_nettype wire

// File: verilog/vlane_shift_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vlane_shift_unit #(
  parameter int NUM_LANES  = 4,      // 1 up to vlane_data_pkg::MAX_LANES
  parameter int ELEM_WIDTH = 32,     // 32 or 16
  parameter int LOW_BITS   = 2       // amount bits done in the second cycle
) (
  input  wire                                        clk,
  input  wire                                        reset,
  input  wire                                        issue,
  input  vlane_isa_pkg::instr_t                      instr,
  input  wire [vlane_data_pkg::MAX_AMOUNT_BITS-1:0]  scalar_amount,
  input  wire [NUM_LANES-1:0]                        elem_mask,
  input  wire [NUM_LANES*ELEM_WIDTH-1:0]             operand,
  output vlane_data_pkg::result_t                    result,
  output wire [NUM_LANES*ELEM_WIDTH-1:0]             result_data
);

  import vlane_isa_pkg::*;

  localparam int AMOUNT_BITS = $clog2(ELEM_WIDTH);

  shift_ctrl_t                     ctrl;        // decode stage
  shift_ctrl_t                     ctrl_late;   // aligned with shifter output
  wire [NUM_LANES*ELEM_WIDTH-1:0]  operand_q;
  wire [NUM_LANES*ELEM_WIDTH-1:0]  shifted_data;

  vlane_shift_decode #(
    .NUM_LANES  (NUM_LANES),
    .ELEM_WIDTH (ELEM_WIDTH)
  ) u_decode (
    .clk           (clk),
    .reset         (reset),
    .issue         (issue),
    .instr         (instr),
    .scalar_amount (scalar_amount),
    .elem_mask     (elem_mask),
    .operand       (operand),
    .ctrl          (ctrl),
    .ctrl_late     (ctrl_late),
    .operand_q     (operand_q)
  );

  // one shifter per element, all fed the same op and amount
  // only the low AMOUNT_BITS of the amount reach the lanes, so it wraps
  for (genvar i = 0; i < NUM_LANES; i++) begin : u_lane
    vlane_barrelshifter #(
      .ELEM_WIDTH  (ELEM_WIDTH),
      .AMOUNT_BITS (AMOUNT_BITS),
      .LOW_BITS    (LOW_BITS)
    ) u_shifter (
      .clk     (clk),
      .reset   (reset),
      .op      (ctrl.op),
      .amount  (ctrl.amount[AMOUNT_BITS-1:0]),
      .opb     (operand_q[i*ELEM_WIDTH +: ELEM_WIDTH]),
      .shifted (shifted_data[i*ELEM_WIDTH +: ELEM_WIDTH])
    );
  end

  vlane_shift_result #(
    .NUM_LANES  (NUM_LANES),
    .ELEM_WIDTH (ELEM_WIDTH)
  ) u_result (
    .clk          (clk),
    .reset        (reset),
    .ctrl_late    (ctrl_late),
    .shifted_data (shifted_data),
    .result       (result),
    .result_data  (result_data)
  );

endmodule

`default_nettype wire

// File: bench/tb_vlane_shift_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vlane_shift_unit;

  import vlane_isa_pkg::*;
  import vlane_data_pkg::*;

  localparam int NUM_LANES  = 4;   // DUT defaults
  localparam int ELEM_WIDTH = 32;
  localparam int DATA_BITS  = NUM_LANES * ELEM_WIDTH;

  // one outstanding instruction as the checker expects to see it
  typedef struct packed {
    logic                 illegal;
    logic [4:0]           dest;
    logic [MAX_LANES-1:0] mask;
    logic [DATA_BITS-1:0] data;
    logic [31:0]          issue_cycle;
  } expect_t;

  logic                 clk;
  logic                 reset;
  logic                 issue;
  instr_t               instr;
  logic [5:0]           scalar_amount;
  logic [NUM_LANES-1:0] elem_mask;
  logic [DATA_BITS-1:0] operand;
  result_t              result;
  wire  [DATA_BITS-1:0] result_data;

  expect_t     exp_q[$];
  expect_t     got_exp;
  logic [31:0] rng_state;
  logic [31:0] cycle_count;
  logic [4:0]  dest_next;
  int          errors;
  int          tests_passed;
  int          tests_failed;

  vlane_shift_unit u_vlane_shift_unit (
    .clk           (clk),
    .reset         (reset),
    .issue         (issue),
    .instr         (instr),
    .scalar_amount (scalar_amount),
    .elem_mask     (elem_mask),
    .operand       (operand),
    .result        (result),
    .result_data   (result_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 32'd1;   // used to measure the latency
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // expected element, built bit by bit from the shift rules
  function automatic logic [ELEM_WIDTH-1:0] ref_shift(input logic [3:0] opcode,
                                                      input logic [5:0] amount,
                                                      input logic [ELEM_WIDTH-1:0] x);
    int n;
    logic [ELEM_WIDTH-1:0] r;
    n = int'(amount) % ELEM_WIDTH;   // amount wraps at the element width
    for (int i = 0; i < ELEM_WIDTH; i++) begin
      if (opcode == OPC_SLL) begin
        r[i] = (i >= n) ? x[i-n] : 1'b0;
      end else if (opcode == OPC_SRL) begin
        r[i] = (i + n < ELEM_WIDTH) ? x[i+n] : 1'b0;
      end else begin
        r[i] = (i + n < ELEM_WIDTH) ? x[i+n] : x[ELEM_WIDTH-1];
      end
    end
    return r;
  endfunction

  function automatic logic [DATA_BITS-1:0] rand_operand();
    logic [DATA_BITS-1:0] v;
    for (int i = 0; i < NUM_LANES; i++) begin
      v[i*ELEM_WIDTH +: ELEM_WIDTH] = next_rand();
    end
    v[ELEM_WIDTH-1]   = 1'b1;   // lane 0 always negative
    v[2*ELEM_WIDTH-1] = 1'b0;   // lane 1 always positive
    return v;
  endfunction

  function automatic logic [3:0] pick_op(input logic [31:0] r);
    if (r % 32'd3 == 32'd0) begin
      return OPC_SLL;
    end else if (r % 32'd3 == 32'd1) begin
      return OPC_SRL;
    end
    return OPC_SRA;
  endfunction

  // drives one issue cycle and queues what should come back
  task automatic issue_one(input logic [3:0] opcode, input logic amt_src,
                           input logic [5:0] imm, input logic [5:0] scalar,
                           input logic [NUM_LANES-1:0] mask,
                           input logic [DATA_BITS-1:0] data);
    expect_t    e;
    logic [5:0] amt;
    logic       legal;
    amt   = amt_src ? scalar : imm;
    legal = (opcode == OPC_SLL) || (opcode == OPC_SRL) || (opcode == OPC_SRA);
    e             = '0;
    e.illegal     = !legal;
    e.dest        = dest_next;
    e.issue_cycle = cycle_count;
    if (legal) begin
      e.mask[NUM_LANES-1:0] = mask;
      for (int i = 0; i < NUM_LANES; i++) begin
        if (mask[i]) begin
          e.data[i*ELEM_WIDTH +: ELEM_WIDTH] =
            ref_shift(opcode, amt, data[i*ELEM_WIDTH +: ELEM_WIDTH]);
        end
      end
    end
    instr.opcode  = opcode;
    instr.dest    = dest_next;
    instr.amt_src = amt_src;
    instr.imm     = imm;
    scalar_amount = scalar;
    elem_mask     = mask;
    operand       = data;
    issue         = 1'b1;
    exp_q.push_back(e);
    dest_next = dest_next + 5'd1;
    @(posedge clk);
    #1;
    issue = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < 20) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (exp_q.size() > 0) begin
      $display("ERROR at %0t: no result arrived within 20 cycles, %0d outstanding",
               $time, exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, errors - errors_before);
    end
  endtask

  // every result pulse is matched against the oldest outstanding issue
  always @(negedge clk) begin
    if (!reset && result.valid) begin
      assert (exp_q.size() > 0) else begin
        $display("ERROR at %0t: result.valid pulsed with no instruction outstanding", $time);
        errors++;
      end
      if (exp_q.size() > 0) begin
        got_exp = exp_q.pop_front();
        assert (cycle_count - got_exp.issue_cycle == 32'd3) else begin
          $display("CHECK FAILED at %0t: latency %0d cycles, expected 3", $time,
                   cycle_count - got_exp.issue_cycle);
          errors++;
        end
        assert (result.illegal == got_exp.illegal && result.dest == got_exp.dest) else begin
          $display("CHECK FAILED at %0t: illegal/dest got %b/%0d expected %b/%0d", $time,
                   result.illegal, result.dest, got_exp.illegal, got_exp.dest);
          errors++;
        end
        assert (result.write_mask == got_exp.mask) else begin
          $display("CHECK FAILED at %0t: write_mask got %h expected %h", $time,
                   result.write_mask, got_exp.mask);
          errors++;
        end
        assert (result_data == got_exp.data) else begin
          $display("CHECK FAILED at %0t: result_data got %h expected %h", $time,
                   result_data, got_exp.data);
          errors++;
        end
      end
    end
  end

  task automatic reset_idle();
    int e0;
    e0 = errors;
    repeat (10) begin
      @(negedge clk);
      assert (result.valid == 1'b0 && result.write_mask == '0) else begin
        $display("CHECK FAILED at %0t: idle after reset shows valid %b write_mask %h",
                 $time, result.valid, result.write_mask);
        errors++;
      end
    end
    @(posedge clk);
    #1;
    finish_test("reset_idle", e0);
  endtask

  task automatic immediate_shifts();
    int         e0;
    int         amts[6];
    logic [3:0] ops[3];
    e0   = errors;
    amts = '{0, 1, 3, 4, 17, 31};
    ops  = '{OPC_SLL, OPC_SRL, OPC_SRA};
    for (int k = 0; k < 3; k++) begin
      for (int j = 0; j < 6; j++) begin
        issue_one(ops[k], AMT_IMM, 6'(amts[j]), 6'd0, '1, rand_operand());
        wait_drain();   // one at a time so latency stands alone
      end
    end
    finish_test("immediate_shifts", e0);
  endtask

  task automatic scalar_amounts();
    int          e0;
    logic [31:0] r;
    e0 = errors;
    issue_one(OPC_SLL, AMT_SCALAR, 6'd5, 6'd32, '1, rand_operand());   // wraps to 0
    issue_one(OPC_SRA, AMT_SCALAR, 6'd1, 6'd40, '1, rand_operand());
    issue_one(OPC_SRL, AMT_SCALAR, 6'd2, 6'd63, '1, rand_operand());
    for (int j = 0; j < 12; j++) begin
      r = next_rand();
      issue_one(pick_op(r), AMT_SCALAR, r[13:8], r[21:16], '1, rand_operand());
    end
    wait_drain();
    finish_test("scalar_amounts", e0);
  endtask

  task automatic masked_lanes();
    int          e0;
    logic [31:0] r;
    e0 = errors;
    issue_one(OPC_SRA, AMT_IMM, 6'd7, 6'd0, '0, rand_operand());   // nothing written
    for (int j = 0; j < 12; j++) begin
      r = next_rand();
      issue_one(pick_op(r), r[6], r[13:8], r[21:16], r[NUM_LANES+23:24], rand_operand());
    end
    wait_drain();
    finish_test("masked_lanes", e0);
  endtask

  task automatic back_to_back();
    int          e0;
    logic [31:0] r;
    e0 = errors;
    for (int j = 0; j < 30; j++) begin
      r = next_rand();
      issue_one(pick_op(r), r[6], r[13:8], r[21:16], r[NUM_LANES+23:24], rand_operand());
    end
    wait_drain();
    finish_test("back_to_back", e0);
  endtask

  task automatic illegal_opcode();
    int         e0;
    logic [3:0] bad[3];
    e0  = errors;
    bad = '{4'h0, 4'h7, 4'hf};
    for (int j = 0; j < 3; j++) begin
      issue_one(OPC_SRL, AMT_IMM, 6'd9, 6'd0, '1, rand_operand());
      issue_one(bad[j], AMT_IMM, 6'd9, 6'd0, '1, rand_operand());
      issue_one(OPC_SLL, AMT_SCALAR, 6'd0, 6'd12, '1, rand_operand());
    end
    wait_drain();
    finish_test("illegal_opcode", e0);
  endtask

  initial begin
    reset         = 1'b1;
    issue         = 1'b0;
    instr         = '0;
    scalar_amount = '0;
    elem_mask     = '0;
    operand       = '0;
    rng_state     = 32'h18d0824d;
    cycle_count   = '0;
    dest_next     = '0;
    errors        = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    reset_idle();
    immediate_shifts();
    scalar_amounts();
    masked_lanes();
    back_to_back();
    illegal_opcode();

    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlane_shift_unit.f
verilog/vlane_data_pkg.sv
verilog/vlane_isa_pkg.sv
verilog/vlane_shift_decode.sv
verilog/vlane_barrelshifter.sv
verilog/vlane_shift_result.sv
verilog/vlane_shift_unit.sv
bench/tb_vlane_shift_unit.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_vlane_shift_unit \
  -f vlane_shift_unit.f \
  -o sim_vlane_shift_unit \
  || { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/sim_vlane_shift_unit 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qx "Simulation PASSED" && exit 0 || exit 1
